// ==== hw/fb_pkg.sv ====
// Frontend bus package with widths, address map, latencies, bus structs and arbiter states
package fb_pkg;

   // Bus widths
   localparam int AW = 32;
   localparam int DW = 32;

   typedef logic [AW-1:0]   addr_t;
   typedef logic [DW-1:0]   data_t;
   // All zero means read
   typedef logic [DW/8-1:0] wmask_t;

   // Targets behind the router
   localparam int N_TGT    = 2;
   localparam int TGT_SRAM = 0;
   localparam int TGT_REGS = 1;

   // SRAM geometry, word addressed
   localparam int SRAM_WORDS = 256;
   localparam int SRAM_AW    = 8;
   typedef logic [SRAM_AW-1:0] sram_idx_t;

   // Register window, 64 KiB, decoded on the upper address bits
   localparam addr_t REG_BASE    = 32'h0001_0000;
   localparam int    REG_WIN_AW  = 16;
   localparam addr_t REG_WIN_MSK = {{(AW-REG_WIN_AW){1'b1}}, {REG_WIN_AW{1'b0}}};
   localparam int    REG_WORDS   = 4;
   localparam int    REG_IW      = $clog2(REG_WORDS);
   typedef logic [REG_IW-1:0] reg_idx_t;

   // Cycles from command handshake to response valid
   localparam int SRAM_LAT = 1;
   localparam int REG_LAT  = 2;

   typedef struct packed {
      addr_t  addr;
      wmask_t we_msk;
      data_t  wdata;
   } fb_cmd_t;

   typedef struct packed {
      data_t rdata;
   } fb_rsp_t;

   typedef enum logic {
      ARB_IDLE,
      ARB_BUSY
   } arb_state_e;

   // Byte lanes under the mask take the new word, the rest keep the old one
   function automatic data_t merge_bytes(data_t old_w, data_t new_w, wmask_t msk);
      data_t res;
      for (int b = 0; b < DW/8; b++) begin
         res[b*8 +: 8] = msk[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
      end
      return res;
   endfunction

endpackage

// ==== hw/fb_arbiter.sv ====
// Frontend bus arbiter, round-robin between fetch and load/store with grant held to response
`timescale 1ns/1ps

module fb_arbiter (
   input  logic            clk,
   input  logic            rst,
   // Fetch port
   input  logic            f_cmd_valid,
   output logic            f_cmd_ready,
   input  fb_pkg::fb_cmd_t f_cmd,
   output logic            f_rsp_valid,
   input  logic            f_rsp_ready,
   output fb_pkg::fb_rsp_t f_rsp,
   // Load/store port
   input  logic            d_cmd_valid,
   output logic            d_cmd_ready,
   input  fb_pkg::fb_cmd_t d_cmd,
   output logic            d_rsp_valid,
   input  logic            d_rsp_ready,
   output fb_pkg::fb_rsp_t d_rsp,
   // Shared frontend bus
   output logic            mb_cmd_valid,
   input  logic            mb_cmd_ready,
   output fb_pkg::fb_cmd_t mb_cmd,
   input  logic            mb_rsp_valid,
   output logic            mb_rsp_ready,
   input  fb_pkg::fb_rsp_t mb_rsp
);

   fb_pkg::arb_state_e state_q;
   // Load/store won the previous grant
   logic               last_d_q;
   // Load/store owns the current transaction
   logic               owner_d_q;
   logic               idle;
   logic               grant_f;
   logic               grant_d;
   logic               hs_cmd;
   logic               hs_rsp;
   fb_pkg::fb_cmd_t    f_cmd_rd;

   assign idle = (state_q == fb_pkg::ARB_IDLE);

   // Fetch port is read only
   always_comb begin
      f_cmd_rd        = f_cmd;
      f_cmd_rd.we_msk = '0;
   end

   // Round robin, the loser of the last round wins a tie
   assign grant_d = d_cmd_valid & (~f_cmd_valid | ~last_d_q);
   assign grant_f = f_cmd_valid & ~grant_d;

   // Request passes through combinationally while idle
   assign mb_cmd_valid = idle & (f_cmd_valid | d_cmd_valid);
   assign mb_cmd       = grant_d ? d_cmd : f_cmd_rd;
   assign f_cmd_ready  = idle & grant_f & mb_cmd_ready;
   assign d_cmd_ready  = idle & grant_d & mb_cmd_ready;

   assign hs_cmd = mb_cmd_valid & mb_cmd_ready;
   assign hs_rsp = mb_rsp_valid & mb_rsp_ready;

   // Response steered to the grant owner only
   assign f_rsp_valid  = ~idle & ~owner_d_q & mb_rsp_valid;
   assign d_rsp_valid  = ~idle & owner_d_q & mb_rsp_valid;
   assign mb_rsp_ready = ~idle & (owner_d_q ? d_rsp_ready : f_rsp_ready);
   assign f_rsp        = mb_rsp;
   assign d_rsp        = mb_rsp;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q   <= fb_pkg::ARB_IDLE;
         // Fetch goes first after reset
         last_d_q  <= 1'b1;
         owner_d_q <= 1'b0;
      end else begin
         case (state_q)
            fb_pkg::ARB_IDLE: begin
               if (hs_cmd) begin
                  state_q   <= fb_pkg::ARB_BUSY;
                  owner_d_q <= grant_d;
                  last_d_q  <= grant_d;
               end
            end
            fb_pkg::ARB_BUSY: begin
               // Grant released at the response handshake
               if (hs_rsp) begin
                  state_q <= fb_pkg::ARB_IDLE;
               end
            end
            default: state_q <= fb_pkg::ARB_IDLE;
         endcase
      end
   end

   // No target may answer while nothing is outstanding
   a_no_rsp_idle: assert property (@(posedge clk) disable iff (rst)
      idle |-> !mb_rsp_valid)
      else $error("arbiter: response valid while idle");

endmodule

// ==== hw/fb_router.sv ====
// Frontend bus router, decodes the address, fans commands out and merges target responses
`timescale 1ns/1ps

module fb_router (
   input  logic                      clk,
   input  logic                      rst,
   // Frontend side
   input  logic                      mb_cmd_valid,
   output logic                      mb_cmd_ready,
   input  fb_pkg::fb_cmd_t           mb_cmd,
   output logic                      mb_rsp_valid,
   input  logic                      mb_rsp_ready,
   output fb_pkg::fb_rsp_t           mb_rsp,
   // Target side
   output logic [fb_pkg::N_TGT-1:0]  tgt_cmd_valid,
   input  logic [fb_pkg::N_TGT-1:0]  tgt_cmd_ready,
   output fb_pkg::fb_cmd_t           tgt_cmd,
   input  logic [fb_pkg::N_TGT-1:0]  tgt_rsp_valid,
   output logic [fb_pkg::N_TGT-1:0]  tgt_rsp_ready,
   input  fb_pkg::fb_rsp_t           tgt_rsp [fb_pkg::N_TGT]
);

   logic [fb_pkg::N_TGT-1:0] tgt_sel;
   logic [fb_pkg::N_TGT-1:0] hs_cmd;
   logic [fb_pkg::N_TGT-1:0] hs_rsp;
   // Target that owes the frontend a response
   logic [fb_pkg::N_TGT-1:0] rsp_src_q;
   logic                     in_reg_win;

   // Only the register window is decoded, everything else aliases into SRAM
   assign in_reg_win = ((mb_cmd.addr & fb_pkg::REG_WIN_MSK) == fb_pkg::REG_BASE);

   always_comb begin
      tgt_sel                   = '0;
      tgt_sel[fb_pkg::TGT_REGS] = in_reg_win;
      tgt_sel[fb_pkg::TGT_SRAM] = ~in_reg_win;
   end

   // Command fan-out, payload shared by all targets
   assign tgt_cmd       = mb_cmd;
   assign tgt_cmd_valid = tgt_sel & {fb_pkg::N_TGT{mb_cmd_valid}};
   assign mb_cmd_ready  = |(tgt_sel & tgt_cmd_ready);

   // Response ready goes to every target
   assign tgt_rsp_ready = {fb_pkg::N_TGT{mb_rsp_ready}};

   assign hs_cmd = tgt_cmd_valid & tgt_cmd_ready;
   assign hs_rsp = tgt_rsp_valid & tgt_rsp_ready;

   // Source flags, set on command, cleared on response
   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_src_q <= '0;
      end else begin
         for (int i = 0; i < fb_pkg::N_TGT; i++) begin
            if (hs_cmd[i]) begin
               rsp_src_q[i] <= 1'b1;
            end else if (hs_rsp[i]) begin
               rsp_src_q[i] <= 1'b0;
            end
         end
      end
   end

   // AND-OR merge of responses
   always_comb begin
      mb_rsp_valid = 1'b0;
      mb_rsp       = '0;
      for (int i = 0; i < fb_pkg::N_TGT; i++) begin
         mb_rsp_valid = mb_rsp_valid | (rsp_src_q[i] & tgt_rsp_valid[i]);
         mb_rsp.rdata = mb_rsp.rdata | ({fb_pkg::DW{rsp_src_q[i]}} & tgt_rsp[i].rdata);
      end
   end

   // One bus cycle at a time across all targets
   a_src_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(rsp_src_q))
      else $error("router: more than one response source pending");

endmodule

// ==== hw/fb_sram.sv ====
// Byte-masked single-port SRAM target with a one-cycle response held under back-pressure
`timescale 1ns/1ps

module fb_sram (
   input  logic            clk,
   input  logic            rst,
   input  logic            cmd_valid,
   output logic            cmd_ready,
   input  fb_pkg::fb_cmd_t cmd,
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output fb_pkg::fb_rsp_t rsp
);

   fb_pkg::data_t     mem [fb_pkg::SRAM_WORDS];
   fb_pkg::sram_idx_t idx;
   fb_pkg::data_t     merged;
   logic              hs_cmd;

   // Word index, addresses beyond the array wrap around
   assign idx    = cmd.addr[fb_pkg::SRAM_AW+1:2];
   assign merged = fb_pkg::merge_bytes(mem[idx], cmd.wdata, cmd.we_msk);
   assign hs_cmd = cmd_valid & cmd_ready;

   // Stored word doubles as the response
   always_ff @(posedge clk) begin
      if (hs_cmd) begin
         mem[idx]  <= merged;
         rsp.rdata <= merged;
      end
   end

   // Control, ready drops while a response is owed
   always_ff @(posedge clk) begin
      if (rst) begin
         cmd_ready <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         cmd_ready <= ~(hs_cmd | (rsp_valid & ~rsp_ready));
         if (hs_cmd) begin
            rsp_valid <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   // Held response must not move
   a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
      else $error("sram: response changed under back-pressure");

endmodule

// ==== hw/fb_reg_bank.sv ====
// Scratch register bank target, four byte-masked words with a two-cycle response
`timescale 1ns/1ps

module fb_reg_bank (
   input  logic            clk,
   input  logic            rst,
   input  logic            cmd_valid,
   output logic            cmd_ready,
   input  fb_pkg::fb_cmd_t cmd,
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output fb_pkg::fb_rsp_t rsp
);

   fb_pkg::data_t    regs [fb_pkg::REG_WORDS];
   fb_pkg::reg_idx_t idx;
   fb_pkg::data_t    merged;
   // Extra stage between write and response
   logic             pend_q;
   fb_pkg::data_t    pend_data_q;
   logic             hs_cmd;

   // Bits 3:2 pick the word, the rest of the window aliases
   assign idx    = cmd.addr[fb_pkg::REG_IW+1:2];
   assign merged = fb_pkg::merge_bytes(regs[idx], cmd.wdata, cmd.we_msk);
   assign hs_cmd = cmd_valid & cmd_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < fb_pkg::REG_WORDS; i++) begin
            regs[i] <= '0;
         end
      end else if (hs_cmd) begin
         regs[idx] <= merged;
      end
   end

   // Payload path
   always_ff @(posedge clk) begin
      if (hs_cmd) begin
         pend_data_q <= merged;
      end
      if (pend_q) begin
         rsp.rdata <= pend_data_q;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         cmd_ready <= 1'b0;
         pend_q    <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         cmd_ready <= ~(hs_cmd | pend_q | (rsp_valid & ~rsp_ready));
         pend_q    <= hs_cmd;
         if (pend_q) begin
            rsp_valid <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   // Busy from acceptance until the response is taken
   a_no_cmd_pend: assert property (@(posedge clk) disable iff (rst)
      pend_q || rsp_valid |-> !hs_cmd)
      else $error("reg_bank: command accepted with response pending");

endmodule

// ==== hw/fb_top.sv ====
// Frontend bus subsystem top, two requesters through arbiter and router to SRAM and registers
`timescale 1ns/1ps

module fb_top (
   input  logic            clk,
   input  logic            rst,
   // Fetch port
   input  logic            f_cmd_valid,
   output logic            f_cmd_ready,
   input  fb_pkg::fb_cmd_t f_cmd,
   output logic            f_rsp_valid,
   input  logic            f_rsp_ready,
   output fb_pkg::fb_rsp_t f_rsp,
   // Load/store port
   input  logic            d_cmd_valid,
   output logic            d_cmd_ready,
   input  fb_pkg::fb_cmd_t d_cmd,
   output logic            d_rsp_valid,
   input  logic            d_rsp_ready,
   output fb_pkg::fb_rsp_t d_rsp
);

   // Shared frontend bus
   logic                     mb_cmd_valid;
   logic                     mb_cmd_ready;
   fb_pkg::fb_cmd_t          mb_cmd;
   logic                     mb_rsp_valid;
   logic                     mb_rsp_ready;
   fb_pkg::fb_rsp_t          mb_rsp;
   // Per-target buses
   logic [fb_pkg::N_TGT-1:0] tgt_cmd_valid;
   logic [fb_pkg::N_TGT-1:0] tgt_cmd_ready;
   fb_pkg::fb_cmd_t          tgt_cmd;
   logic [fb_pkg::N_TGT-1:0] tgt_rsp_valid;
   logic [fb_pkg::N_TGT-1:0] tgt_rsp_ready;
   fb_pkg::fb_rsp_t          tgt_rsp [fb_pkg::N_TGT];

   fb_arbiter u_arbiter (
      .clk          (clk),
      .rst          (rst),
      .f_cmd_valid  (f_cmd_valid),
      .f_cmd_ready  (f_cmd_ready),
      .f_cmd        (f_cmd),
      .f_rsp_valid  (f_rsp_valid),
      .f_rsp_ready  (f_rsp_ready),
      .f_rsp        (f_rsp),
      .d_cmd_valid  (d_cmd_valid),
      .d_cmd_ready  (d_cmd_ready),
      .d_cmd        (d_cmd),
      .d_rsp_valid  (d_rsp_valid),
      .d_rsp_ready  (d_rsp_ready),
      .d_rsp        (d_rsp),
      .mb_cmd_valid (mb_cmd_valid),
      .mb_cmd_ready (mb_cmd_ready),
      .mb_cmd       (mb_cmd),
      .mb_rsp_valid (mb_rsp_valid),
      .mb_rsp_ready (mb_rsp_ready),
      .mb_rsp       (mb_rsp)
   );

   fb_router u_router (
      .clk           (clk),
      .rst           (rst),
      .mb_cmd_valid  (mb_cmd_valid),
      .mb_cmd_ready  (mb_cmd_ready),
      .mb_cmd        (mb_cmd),
      .mb_rsp_valid  (mb_rsp_valid),
      .mb_rsp_ready  (mb_rsp_ready),
      .mb_rsp        (mb_rsp),
      .tgt_cmd_valid (tgt_cmd_valid),
      .tgt_cmd_ready (tgt_cmd_ready),
      .tgt_cmd       (tgt_cmd),
      .tgt_rsp_valid (tgt_rsp_valid),
      .tgt_rsp_ready (tgt_rsp_ready),
      .tgt_rsp       (tgt_rsp)
   );

   fb_sram u_sram (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (tgt_cmd_valid[fb_pkg::TGT_SRAM]),
      .cmd_ready (tgt_cmd_ready[fb_pkg::TGT_SRAM]),
      .cmd       (tgt_cmd),
      .rsp_valid (tgt_rsp_valid[fb_pkg::TGT_SRAM]),
      .rsp_ready (tgt_rsp_ready[fb_pkg::TGT_SRAM]),
      .rsp       (tgt_rsp[fb_pkg::TGT_SRAM])
   );

   fb_reg_bank u_reg_bank (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (tgt_cmd_valid[fb_pkg::TGT_REGS]),
      .cmd_ready (tgt_cmd_ready[fb_pkg::TGT_REGS]),
      .cmd       (tgt_cmd),
      .rsp_valid (tgt_rsp_valid[fb_pkg::TGT_REGS]),
      .rsp_ready (tgt_rsp_ready[fb_pkg::TGT_REGS]),
      .rsp       (tgt_rsp[fb_pkg::TGT_REGS])
   );

endmodule

// ==== test/tb_fb_top.sv ====
// Frontend bus testbench with random two-port traffic checked against a word model
`timescale 1ns/1ps

module tb_fb_top;

   localparam int N_CMDS     = 300;
   // 40 cycles of 4 ns for every command of both ports
   localparam int TIMEOUT_NS = 2 * N_CMDS * 40 * 4;

   logic clk = 1'b0;
   logic rst;
   // Index 0 is fetch, index 1 is load/store
   logic [1:0]            cmd_v;
   logic [1:0]            cmd_r;
   fb_pkg::fb_cmd_t [1:0] cmd_p;
   logic [1:0]            rsp_v;
   logic [1:0]            rsp_r;
   fb_pkg::fb_rsp_t [1:0] rsp_p;

   int              seed;
   fb_pkg::fb_cmd_t cmds [2][N_CMDS];
   int              gaps [2][N_CMDS];
   // Model keyed by aliased word, registers sit above the SRAM words
   fb_pkg::data_t   model_word [int];
   // Bytes with a defined value, SRAM powers up unknown
   fb_pkg::data_t   model_known [int];
   // Scoreboard, at most one transaction per port
   logic            pend [2] = '{1'b0, 1'b0};
   logic            seen [2] = '{1'b0, 1'b0};
   logic            held [2] = '{1'b0, 1'b0};
   fb_pkg::fb_rsp_t held_rsp [2];
   fb_pkg::fb_rsp_t exp_rsp [2];
   fb_pkg::data_t   exp_care [2];
   int              due [2];
   int              rsp_cnt [2] = '{0, 0};
   int              cyc = 0;

   always #2 clk = ~clk;

   fb_top DUT (
      .clk         (clk),
      .rst         (rst),
      .f_cmd_valid (cmd_v[0]),
      .f_cmd_ready (cmd_r[0]),
      .f_cmd       (cmd_p[0]),
      .f_rsp_valid (rsp_v[0]),
      .f_rsp_ready (rsp_r[0]),
      .f_rsp       (rsp_p[0]),
      .d_cmd_valid (cmd_v[1]),
      .d_cmd_ready (cmd_r[1]),
      .d_cmd       (cmd_p[1]),
      .d_rsp_valid (rsp_v[1]),
      .d_rsp_ready (rsp_r[1]),
      .d_rsp       (rsp_p[1])
   );

   task automatic stop_run(string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_rsp(string name, fb_pkg::fb_rsp_t got, fb_pkg::fb_rsp_t exp,
                            fb_pkg::data_t care);
      if ((got.rdata & care) !== (exp.rdata & care)) begin
         stop_run($sformatf("[FAIL] %s got %h expected %h care %h",
                            name, got.rdata, exp.rdata, care));
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
      end
   endtask

   // Register window wraps every four words, anything else lands in the SRAM
   function automatic int word_key(fb_pkg::addr_t a);
      if (a[31:16] == fb_pkg::REG_BASE[31:16]) begin
         return fb_pkg::SRAM_WORDS + int'(a[31:2]) % fb_pkg::REG_WORDS;
      end
      return int'(a[31:2]) % fb_pkg::SRAM_WORDS;
   endfunction

   // Masked bytes come from the new word
   function automatic fb_pkg::data_t apply_mask(fb_pkg::data_t old_w, fb_pkg::data_t new_w,
                                                fb_pkg::wmask_t msk);
      fb_pkg::data_t res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (msk[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   function automatic fb_pkg::fb_cmd_t random_cmd();
      fb_pkg::fb_cmd_t c;
      logic            pick_reg;
      pick_reg = 1'($random(seed));
      c.addr   = fb_pkg::addr_t'($random(seed));
      // Bits 11:10 and the upper half alias, bit 16 clear keeps it out of the registers
      if (pick_reg) begin
         c.addr = (c.addr & 32'h0000_FFFF) | fb_pkg::REG_BASE;
      end else begin
         c.addr = c.addr & 32'hFFFE_FCFF;
      end
      c.we_msk = fb_pkg::wmask_t'($random(seed));
      c.wdata  = fb_pkg::data_t'($random(seed));
      // About half plain reads
      if (1'($random(seed))) begin
         c.we_msk = '0;
      end
      return c;
   endfunction

   task automatic drive_port(int p);
      for (int i = 0; i < N_CMDS; i++) begin
         repeat (gaps[p][i]) begin
            @(posedge clk);
            #1;
         end
         cmd_v[p] = 1'b1;
         cmd_p[p] = cmds[p][i];
         // Held until the handshake edge
         do begin
            @(negedge clk);
         end while (!cmd_r[p]);
         @(posedge clk);
         #1;
         cmd_v[p] = 1'b0;
      end
   endtask

   task automatic drive_ready();
      while (rsp_cnt[0] < N_CMDS || rsp_cnt[1] < N_CMDS) begin
         @(posedge clk);
         #1;
         // Back-pressure about one cycle in four
         rsp_r[0] = (($random(seed) & 3) != 0);
         rsp_r[1] = (($random(seed) & 3) != 0);
      end
   endtask

   task automatic observe(int p);
      string          pn;
      int             k;
      fb_pkg::wmask_t msk;
      pn = (p == 0) ? "f" : "d";
      if (rsp_v[p] && !pend[p]) begin
         stop_run($sformatf("%s port saw a response with no command outstanding", pn));
      end
      // Held response keeps valid and payload
      if (held[p]) begin
         check_bit({pn, "_rsp_valid"}, rsp_v[p], 1'b1);
         check_rsp({pn, "_rsp held"}, rsp_p[p], held_rsp[p], '1);
      end
      // First valid exactly at target latency
      if (pend[p] && !seen[p]) begin
         check_bit({pn, "_rsp_valid"}, rsp_v[p], cyc >= due[p]);
         seen[p] = rsp_v[p];
      end
      if (rsp_v[p]) begin
         check_rsp({pn, "_rsp"}, rsp_p[p], exp_rsp[p], exp_care[p]);
      end
      held[p]     = rsp_v[p] & ~rsp_r[p];
      held_rsp[p] = rsp_p[p];
      if (rsp_v[p] && rsp_r[p]) begin
         pend[p] = 1'b0;
         rsp_cnt[p]++;
      end
      // Command taken at the coming edge, model follows bus order
      if (cmd_v[p] && cmd_r[p]) begin
         k = word_key(cmd_p[p].addr);
         if (!model_word.exists(k)) begin
            model_word[k]  = '0;
            model_known[k] = '0;
            // Registers reset to zero
            if (k >= fb_pkg::SRAM_WORDS) begin
               model_known[k] = '1;
            end
         end
         msk = cmd_p[p].we_msk;
         if (p == 0) begin
            msk = '0;
         end
         model_word[k]    = apply_mask(model_word[k], cmd_p[p].wdata, msk);
         model_known[k]   = apply_mask(model_known[k], '1, msk);
         exp_rsp[p].rdata = model_word[k];
         exp_care[p]      = model_known[k];
         pend[p]          = 1'b1;
         seen[p]          = 1'b0;
         due[p] = cyc + ((k >= fb_pkg::SRAM_WORDS) ? fb_pkg::REG_LAT : fb_pkg::SRAM_LAT);
      end
   endtask

   // Sampled mid-cycle, inputs settle at 1 ns after the rising edge
   always @(negedge clk) begin
      if (!rst) begin
         cyc++;
         observe(0);
         observe(1);
      end
   end

   initial begin
      #(TIMEOUT_NS);
      stop_run("watchdog expired with responses still missing");
   end

   initial begin
      seed  = 32'hae3bd996;
      rst   = 1'b1;
      cmd_v = '0;
      cmd_p = '0;
      rsp_r = '0;
      for (int p = 0; p < 2; p++) begin
         for (int i = 0; i < N_CMDS; i++) begin
            cmds[p][i] = random_cmd();
            gaps[p][i] = $random(seed) & 3;
         end
      end
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      // Both ports request while the targets still come out of reset
      cmd_v = '1;
      // Quiet outputs straight after reset
      @(negedge clk);
      check_bit("f_cmd_ready", cmd_r[0], 1'b0);
      check_bit("d_cmd_ready", cmd_r[1], 1'b0);
      check_bit("f_rsp_valid", rsp_v[0], 1'b0);
      check_bit("d_rsp_valid", rsp_v[1], 1'b0);
      @(posedge clk);
      #1;
      cmd_v = '0;
      fork
         drive_port(0);
         drive_port(1);
         drive_ready();
      join
      if (!pend[0] && !pend[1] && rsp_cnt[0] == N_CMDS && rsp_cnt[1] == N_CMDS) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         stop_run($sformatf("response count wrong, fetch %0d load/store %0d of %0d",
                            rsp_cnt[0], rsp_cnt[1], N_CMDS));
      end
   end

endmodule

// ==== flist.f ====
hw/fb_pkg.sv
hw/fb_arbiter.sv
hw/fb_router.sv
hw/fb_sram.sv
hw/fb_reg_bank.sv
hw/fb_top.sv
test/tb_fb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the frontend bus testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_fb_top -f flist.f -o tb_fb_top_sim
out="$(./obj_dir/tb_fb_top_sim || true)"
echo "$out"
if echo "$out" | grep -qx "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
